// ==== logic/raster_consts.svh ====
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// frame buffer geometry in pixels
`define RASTER_SCREEN_W 640
`define RASTER_SCREEN_H 480

// pixels the sink can hold before returning credits
`define RASTER_CREDITS 4

// each pixel slot is 8 bytes wide
`define RASTER_PIXEL_SHIFT 3

`endif

// ==== logic/raster_pkg.sv ====
package raster_pkg;

    // integer pixel coordinate, signed so off-screen vertices work
    typedef logic signed [15:0] coord_t;

    // edge function values, coefficients and doubled area
    typedef logic signed [31:0] edge_t;

    typedef logic [25:0] pixel_addr_t; // frame buffer byte address
    typedef logic [23:0] color_t;      // packed rgb
    typedef logic [2:0]  credit_t;     // holds 0 to RASTER_CREDITS

    typedef enum logic [2:0] {
        RS_IDLE,
        RS_SETUP,
        RS_WALK,
        RS_DRAIN,
        RS_DONE
    } raster_state_t;

endpackage

// ==== logic/triangle_setup.sv ====
`timescale 1ns/1ps
`include "raster_consts.svh"

module triangle_setup (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load,
    input  raster_pkg::coord_t      x1,
    input  raster_pkg::coord_t      y1,
    input  raster_pkg::coord_t      x2,
    input  raster_pkg::coord_t      y2,
    input  raster_pkg::coord_t      x3,
    input  raster_pkg::coord_t      y3,
    input  raster_pkg::color_t      color1,
    input  raster_pkg::pixel_addr_t fb_base,
    output raster_pkg::coord_t      box_min_x,
    output raster_pkg::coord_t      box_min_y,
    output raster_pkg::coord_t      box_max_x,
    output raster_pkg::coord_t      box_max_y,
    output raster_pkg::edge_t       a12,
    output raster_pkg::edge_t       b12,
    output raster_pkg::edge_t       a23,
    output raster_pkg::edge_t       b23,
    output raster_pkg::edge_t       a31,
    output raster_pkg::edge_t       b31,
    output raster_pkg::coord_t      anchor_x1,
    output raster_pkg::coord_t      anchor_y1,
    output raster_pkg::coord_t      anchor_x2,
    output raster_pkg::coord_t      anchor_y2,
    output raster_pkg::coord_t      anchor_x3,
    output raster_pkg::coord_t      anchor_y3,
    output raster_pkg::color_t      flat_color,
    output raster_pkg::pixel_addr_t base,
    output logic                    setup_done,
    output logic                    degenerate
);
    import raster_pkg::*;

    logic   vtx_valid;
    logic   mm_valid;
    coord_t raw_min_x;
    coord_t raw_min_y;
    coord_t raw_max_x;
    coord_t raw_max_y;
    coord_t clip_min_x;
    coord_t clip_min_y;
    coord_t clip_max_x;
    coord_t clip_max_y;
    edge_t  area;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    always_comb begin
        clip_min_x = (raw_min_x < 0) ? coord_t'(0) : raw_min_x;
        clip_min_y = (raw_min_y < 0) ? coord_t'(0) : raw_min_y;
        clip_max_x = (raw_max_x > `RASTER_SCREEN_W - 1) ? coord_t'(`RASTER_SCREEN_W - 1) : raw_max_x;
        clip_max_y = (raw_max_y > `RASTER_SCREEN_H - 1) ? coord_t'(`RASTER_SCREEN_H - 1) : raw_max_y;
        // edge 12 evaluated at vertex 3, positive for the accepted winding
        area = (edge_t'(anchor_x3) - edge_t'(anchor_x1)) * (edge_t'(anchor_y2) - edge_t'(anchor_y1))
             - (edge_t'(anchor_y3) - edge_t'(anchor_y1)) * (edge_t'(anchor_x2) - edge_t'(anchor_x1));
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            vtx_valid  <= 1'b0;
            mm_valid   <= 1'b0;
            setup_done <= 1'b0;
            degenerate <= 1'b0;
        end else begin
            vtx_valid  <= load;
            mm_valid   <= vtx_valid;
            setup_done <= mm_valid; // two cycles after the accepting edge
            if (mm_valid)
                degenerate <= (area <= 0) || (clip_min_x > clip_max_x) || (clip_min_y > clip_max_y);
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            anchor_x1  <= x1;
            anchor_y1  <= y1;
            anchor_x2  <= x2;
            anchor_y2  <= y2;
            anchor_x3  <= x3;
            anchor_y3  <= y3;
            flat_color <= color1; // vertex 1 is the provoking vertex
            base       <= fb_base;
        end
        if (vtx_valid) begin
            raw_min_x <= min3(anchor_x1, anchor_x2, anchor_x3);
            raw_min_y <= min3(anchor_y1, anchor_y2, anchor_y3);
            raw_max_x <= max3(anchor_x1, anchor_x2, anchor_x3);
            raw_max_y <= max3(anchor_y1, anchor_y2, anchor_y3);
        end
        if (mm_valid) begin
            box_min_x <= clip_min_x;
            box_min_y <= clip_min_y;
            box_max_x <= clip_max_x;
            box_max_y <= clip_max_y;
            a12 <= edge_t'(anchor_x2) - edge_t'(anchor_x1);
            b12 <= edge_t'(anchor_y2) - edge_t'(anchor_y1);
            a23 <= edge_t'(anchor_x3) - edge_t'(anchor_x2);
            b23 <= edge_t'(anchor_y3) - edge_t'(anchor_y2);
            a31 <= edge_t'(anchor_x1) - edge_t'(anchor_x3);
            b31 <= edge_t'(anchor_y1) - edge_t'(anchor_y3);
        end
    end

endmodule

// ==== logic/scan_walker.sv ====
`timescale 1ns/1ps

module scan_walker (
    input  logic               clock,
    input  logic               reset,
    input  logic               setup_go,
    input  logic               advance,
    input  raster_pkg::coord_t box_min_x,
    input  raster_pkg::coord_t box_min_y,
    input  raster_pkg::coord_t box_max_x,
    input  raster_pkg::coord_t box_max_y,
    output raster_pkg::coord_t sample_x,
    output raster_pkg::coord_t sample_y,
    output logic               sample_valid,
    output logic               sample_last
);
    import raster_pkg::*;

    logic row_end;

    assign row_end     = (sample_x == box_max_x);
    assign sample_last = sample_valid && row_end && (sample_y == box_max_y);

    // raster order, left to right then top to bottom
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            sample_valid <= 1'b0;
            sample_x     <= '0;
            sample_y     <= '0;
        end else if (setup_go) begin
            sample_valid <= 1'b1;
            sample_x     <= box_min_x;
            sample_y     <= box_min_y;
        end else if (advance && sample_valid) begin
            if (sample_last) begin
                sample_valid <= 1'b0; // box exhausted
            end else if (row_end) begin
                sample_x <= box_min_x;
                sample_y <= sample_y + coord_t'(1);
            end else begin
                sample_x <= sample_x + coord_t'(1);
            end
        end
    end

endmodule

// ==== logic/edge_evaluator.sv ====
`timescale 1ns/1ps
`include "raster_consts.svh"

module edge_evaluator (
    input  logic                    clock,
    input  logic                    reset,
    input  raster_pkg::coord_t      sample_x,
    input  raster_pkg::coord_t      sample_y,
    input  logic                    sample_valid,
    input  logic                    sample_last,
    input  raster_pkg::edge_t       a12,
    input  raster_pkg::edge_t       b12,
    input  raster_pkg::edge_t       a23,
    input  raster_pkg::edge_t       b23,
    input  raster_pkg::edge_t       a31,
    input  raster_pkg::edge_t       b31,
    input  raster_pkg::coord_t      anchor_x1,
    input  raster_pkg::coord_t      anchor_y1,
    input  raster_pkg::coord_t      anchor_x2,
    input  raster_pkg::coord_t      anchor_y2,
    input  raster_pkg::coord_t      anchor_x3,
    input  raster_pkg::coord_t      anchor_y3,
    input  raster_pkg::color_t      flat_color,
    input  raster_pkg::pixel_addr_t base,
    input  logic                    has_credit,
    output logic                    stage_ready,
    output logic                    pixel_valid,
    output raster_pkg::pixel_addr_t pixel_addr,
    output raster_pkg::edge_t       pixel_w1,
    output raster_pkg::edge_t       pixel_w2,
    output raster_pkg::edge_t       pixel_w3,
    output raster_pkg::color_t      pixel_color,
    output logic                    eval_last_out
);
    import raster_pkg::*;

    edge_t       w1_next;
    edge_t       w2_next;
    edge_t       w3_next;
    pixel_addr_t pix_index;
    logic        st_valid;
    logic        st_last;
    logic        st_inside;

    // (x - xa) * (yb - ya) - (y - ya) * (xb - xa)
    function automatic edge_t edge_value(input coord_t x, input coord_t y,
                                         input coord_t xa, input coord_t ya,
                                         input edge_t a, input edge_t b);
        edge_t dx;
        edge_t dy;
        dx = edge_t'(x) - edge_t'(xa);
        dy = edge_t'(y) - edge_t'(ya);
        return dx * b - dy * a;
    endfunction

    always_comb begin
        w1_next   = edge_value(sample_x, sample_y, anchor_x1, anchor_y1, a12, b12);
        w2_next   = edge_value(sample_x, sample_y, anchor_x2, anchor_y2, a23, b23);
        w3_next   = edge_value(sample_x, sample_y, anchor_x3, anchor_y3, a31, b31);
        pix_index = pixel_addr_t'(sample_y) * pixel_addr_t'(`RASTER_SCREEN_W)
                  + pixel_addr_t'(sample_x);
    end

    // only an inside sample waits for a credit
    assign stage_ready   = !(st_valid && st_inside && !has_credit);
    assign pixel_valid   = st_valid && st_inside && has_credit;
    assign eval_last_out = st_valid && st_last && stage_ready;
    assign pixel_color   = flat_color; // flat shading

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            st_valid <= 1'b0;
        else if (stage_ready)
            st_valid <= sample_valid;
    end

    always_ff @(posedge clock) begin
        if (stage_ready && sample_valid) begin
            st_last    <= sample_last;
            st_inside  <= (w1_next >= 0) && (w2_next >= 0) && (w3_next >= 0);
            pixel_w1   <= w1_next;
            pixel_w2   <= w2_next;
            pixel_w3   <= w3_next;
            pixel_addr <= base + (pix_index << `RASTER_PIXEL_SHIFT);
        end
    end

endmodule

// ==== logic/credit_counter.sv ====
`timescale 1ns/1ps
`include "raster_consts.svh"

module credit_counter (
    input  logic                clock,
    input  logic                reset,
    input  logic                spend,
    input  logic                credit_return,
    output logic                has_credit,
    output raster_pkg::credit_t credits
);
    import raster_pkg::*;

    credit_t credits_next;

    // spend and return in one cycle cancel out
    always_comb begin
        case ({spend, credit_return})
            2'b10:   credits_next = credits - credit_t'(1);
            2'b01:   credits_next = credits + credit_t'(1);
            default: credits_next = credits;
        endcase
    end

    assign has_credit = (credits != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            credits <= credit_t'(`RASTER_CREDITS); // sink starts empty
        else
            credits <= credits_next;
    end

endmodule

// ==== logic/raster_control.sv ====
`timescale 1ns/1ps

module raster_control (
    input  logic clock,
    input  logic reset,
    input  logic tri_valid,
    output logic tri_ready,
    input  logic setup_done,
    input  logic degenerate,
    output logic setup_go,
    output logic walk_enable,
    input  logic walk_last,
    input  logic eval_last_out,
    output logic tri_done
);
    import raster_pkg::*;

    raster_state_t state;
    raster_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            RS_IDLE: begin
                if (tri_valid)
                    state_next = RS_SETUP;
            end
            RS_SETUP: begin
                if (setup_done)
                    state_next = degenerate ? RS_DONE : RS_WALK; // nothing to draw
            end
            RS_WALK: begin
                if (walk_last)
                    state_next = RS_DRAIN; // last sample went into the evaluator
            end
            RS_DRAIN: begin
                if (eval_last_out)
                    state_next = RS_DONE;
            end
            RS_DONE: begin
                state_next = RS_IDLE;
            end
            default: begin
                state_next = RS_IDLE;
            end
        endcase
    end

    assign tri_ready   = (state == RS_IDLE);
    assign setup_go    = (state == RS_SETUP) && setup_done && !degenerate;
    assign walk_enable = (state == RS_WALK);
    assign tri_done    = (state == RS_DONE);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            state <= RS_IDLE;
        else
            state <= state_next;
    end

endmodule

// ==== logic/rasterizer_top.sv ====
`timescale 1ns/1ps

module rasterizer_top (
    input  logic                    clock,
    input  logic                    reset,
    input  raster_pkg::coord_t      x1,
    input  raster_pkg::coord_t      y1,
    input  raster_pkg::coord_t      x2,
    input  raster_pkg::coord_t      y2,
    input  raster_pkg::coord_t      x3,
    input  raster_pkg::coord_t      y3,
    input  raster_pkg::color_t      color1,
    input  raster_pkg::color_t      color2, // flat shading takes vertex 1 only
    input  raster_pkg::color_t      color3,
    input  raster_pkg::pixel_addr_t fb_base,
    input  logic                    tri_valid,
    output logic                    tri_ready,
    output logic                    pixel_valid,
    output raster_pkg::pixel_addr_t pixel_addr,
    output raster_pkg::edge_t       pixel_w1,
    output raster_pkg::edge_t       pixel_w2,
    output raster_pkg::edge_t       pixel_w3,
    output raster_pkg::color_t      pixel_color,
    input  logic                    credit_return,
    output logic                    tri_done
);
    import raster_pkg::*;

    logic        load;
    logic        advance;
    logic        walk_last;
    logic        setup_go;
    logic        walk_enable;
    logic        setup_done;
    logic        degenerate;
    coord_t      box_min_x;
    coord_t      box_min_y;
    coord_t      box_max_x;
    coord_t      box_max_y;
    edge_t       a12;
    edge_t       b12;
    edge_t       a23;
    edge_t       b23;
    edge_t       a31;
    edge_t       b31;
    coord_t      anchor_x1;
    coord_t      anchor_y1;
    coord_t      anchor_x2;
    coord_t      anchor_y2;
    coord_t      anchor_x3;
    coord_t      anchor_y3;
    color_t      flat_color;
    pixel_addr_t base;
    coord_t      sample_x;
    coord_t      sample_y;
    logic        sample_valid;
    logic        sample_last;
    logic        stage_ready;
    logic        has_credit;
    logic        eval_last_out;

    assign load      = tri_valid && tri_ready;
    assign advance   = walk_enable && stage_ready; // walker stalls with the evaluator
    assign walk_last = advance && sample_last;

    raster_control raster_control_i (.*);

    triangle_setup triangle_setup_i (.*);

    scan_walker scan_walker_i (.*);

    edge_evaluator edge_evaluator_i (.*);

    credit_counter credit_counter_i (
        .clock         (clock),
        .reset         (reset),
        .spend         (pixel_valid),
        .credit_return (credit_return),
        .has_credit    (has_credit),
        .credits       ()
    );

endmodule

// ==== verification/rasterizer_asserts.sv ====
`timescale 1ns/1ps
`include "raster_consts.svh"

module rasterizer_asserts (
    input logic                clock,
    input logic                reset,
    input logic                tri_ready,
    input logic                tri_done,
    input logic                spend,
    input raster_pkg::credit_t credits
);

    done_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        tri_done |=> !tri_done)
        else $error("tri_done stayed high for more than one cycle");

    // the input side reopens only through the done pulse
    ready_after_done: assert property (@(posedge clock) disable iff (!reset)
        $rose(tri_ready) |-> $past(tri_done))
        else $error("tri_ready rose without a preceding tri_done");

    idle_after_done: assert property (@(posedge clock) disable iff (!reset)
        tri_done |=> tri_ready)
        else $error("tri_ready low in the cycle after tri_done");

    spend_needs_credit: assert property (@(posedge clock) disable iff (!reset)
        spend |-> (credits != '0))
        else $error("pixel_valid with an empty credit pool");

    credits_bounded: assert property (@(posedge clock) disable iff (!reset)
        credits <= `RASTER_CREDITS)
        else $error("credit count above the pool size");

endmodule

// controller copy with the credit inputs tied off
bind raster_control rasterizer_asserts control_checks (
    .clock     (clock),
    .reset     (reset),
    .tri_ready (tri_ready),
    .tri_done  (tri_done),
    .spend     (1'b0),
    .credits   ('0)
);

// credit pool copy with the controller inputs tied off
bind credit_counter rasterizer_asserts credit_checks (
    .clock     (clock),
    .reset     (reset),
    .tri_ready (1'b1),
    .tri_done  (1'b0),
    .spend     (spend),
    .credits   (credits)
);

// ==== verification/rasterizer_tb.sv ====
`timescale 1ns/1ps
`include "raster_consts.svh"

module rasterizer_tb;
    import raster_pkg::*;

    localparam int MAX_TRIS = 32;
    localparam int TIMEOUT  = 5000; // cycles per wait

    logic        clock;
    logic        reset;
    coord_t      x1;
    coord_t      y1;
    coord_t      x2;
    coord_t      y2;
    coord_t      x3;
    coord_t      y3;
    color_t      color1;
    color_t      color2;
    color_t      color3;
    pixel_addr_t fb_base;
    logic        tri_valid;
    logic        tri_ready;
    logic        pixel_valid;
    pixel_addr_t pixel_addr;
    edge_t       pixel_w1;
    edge_t       pixel_w2;
    edge_t       pixel_w3;
    color_t      pixel_color;
    logic        credit_return;
    logic        tri_done;

    // triangle table from the stimulus file
    int          vx [MAX_TRIS][3];
    int          vy [MAX_TRIS][3];
    color_t      col [MAX_TRIS][3];
    pixel_addr_t fbase [MAX_TRIS];
    int          exp_count [MAX_TRIS];
    pixel_addr_t exp_first [MAX_TRIS];
    pixel_addr_t exp_last [MAX_TRIS];
    int          tri_count = 0;

    int          active [$];     // accepted triangles not yet done
    int          return_due [$]; // cycle at which each owed credit goes back
    int          delay_table [256];
    int          cycle_count = 0;
    int          pix_count = 0;
    int          pixels_total = 0;
    int          outstanding = 0;
    int          done_count = 0;
    pixel_addr_t first_addr;
    pixel_addr_t last_addr;

    rasterizer_top rasterizer_top_i (.*);

    always #2 clock = ~clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input longint actual, input longint expected, input string what);
        if (actual != expected)
            stop_with_failure($sformatf("ERROR at %0t: %s, got %0d, expected %0d",
                                        $time, what, actual, expected));
    endtask

    // (x - xa) * (yb - ya) - (y - ya) * (xb - xa)
    function automatic int edge_fn(input int px, input int py, input int xa, input int ya,
                                   input int xb, input int yb);
        return (px - xa) * (yb - ya) - (py - ya) * (xb - xa);
    endfunction

    function automatic int clip_min(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        m = (c < m) ? c : m;
        return (m < 0) ? 0 : m;
    endfunction

    function automatic int clip_max(input int a, input int b, input int c, input int limit);
        int m;
        m = (a > b) ? a : b;
        m = (c > m) ? c : m;
        return (m > limit - 1) ? limit - 1 : m;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verification/raster_stimulus.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open verification/raster_stimulus.txt");
        while (!$feof(fd) && tri_count < MAX_TRIS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin // skip blanks and column notes
                n = $sscanf(line, "%d %d %d %d %d %d %h %h %h %h %d %h %h",
                            vx[tri_count][0], vy[tri_count][0], vx[tri_count][1],
                            vy[tri_count][1], vx[tri_count][2], vy[tri_count][2],
                            col[tri_count][0], col[tri_count][1], col[tri_count][2],
                            fbase[tri_count], exp_count[tri_count],
                            exp_first[tri_count], exp_last[tri_count]);
                if (n != 13)
                    stop_with_failure("a line of the stimulus file has the wrong format");
                tri_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_triangle(input int t);
        x1        = coord_t'(vx[t][0]);
        y1        = coord_t'(vy[t][0]);
        x2        = coord_t'(vx[t][1]);
        y2        = coord_t'(vy[t][1]);
        x3        = coord_t'(vx[t][2]);
        y3        = coord_t'(vy[t][2]);
        color1    = col[t][0];
        color2    = col[t][1];
        color3    = col[t][2];
        fb_base   = fbase[t];
        tri_valid = 1'b1;
    endtask

    task automatic take_pixel();
        int t;
        int offset;
        int px;
        int py;
        int w [3];
        logic in_box;
        if (active.size() == 0)
            stop_with_failure("a pixel came out with no triangle in progress");
        t = active[0];
        offset = int'(pixel_addr - fbase[t]);
        check_value(offset & ((1 << `RASTER_PIXEL_SHIFT) - 1), 0, "pixel address alignment");
        offset = offset >> `RASTER_PIXEL_SHIFT;
        px = offset % `RASTER_SCREEN_W;
        py = offset / `RASTER_SCREEN_W;
        w[0] = edge_fn(px, py, vx[t][0], vy[t][0], vx[t][1], vy[t][1]);
        w[1] = edge_fn(px, py, vx[t][1], vy[t][1], vx[t][2], vy[t][2]);
        w[2] = edge_fn(px, py, vx[t][2], vy[t][2], vx[t][0], vy[t][0]);
        check_value(pixel_w1, w[0], "edge value w1");
        check_value(pixel_w2, w[1], "edge value w2");
        check_value(pixel_w3, w[2], "edge value w3");
        check_value((w[0] >= 0) && (w[1] >= 0) && (w[2] >= 0), 1, "pixel inside all edges");
        in_box = (px >= clip_min(vx[t][0], vx[t][1], vx[t][2]))
              && (px <= clip_max(vx[t][0], vx[t][1], vx[t][2], `RASTER_SCREEN_W))
              && (py >= clip_min(vy[t][0], vy[t][1], vy[t][2]))
              && (py <= clip_max(vy[t][0], vy[t][1], vy[t][2], `RASTER_SCREEN_H));
        check_value(in_box, 1, "pixel inside clipped bounding box");
        check_value(pixel_color, col[t][0], "pixel colour against vertex 1");
        if (pix_count == 0)
            first_addr = pixel_addr;
        else
            check_value(pixel_addr > last_addr, 1, "raster order with no repeated pixel");
        last_addr = pixel_addr;
        pix_count++;
        outstanding++;
        check_value(outstanding <= `RASTER_CREDITS, 1, "pixels outstanding at the sink");
        return_due.push_back(cycle_count + 1 + delay_table[pixels_total % 256]);
        pixels_total++;
    endtask

    task automatic finish_triangle();
        int t;
        if (active.size() == 0)
            stop_with_failure("tri_done came with no triangle in progress");
        t = active.pop_front(); // done order follows input order
        check_value(pix_count, exp_count[t], $sformatf("pixel count of triangle %0d", t));
        if (exp_count[t] > 0) begin
            check_value(first_addr, exp_first[t], $sformatf("first address of triangle %0d", t));
            check_value(last_addr, exp_last[t], $sformatf("last address of triangle %0d", t));
        end
        pix_count = 0;
        done_count++;
    endtask

    task automatic drive_credit_return();
        if (return_due.size() > 0 && return_due[0] <= cycle_count) begin
            void'(return_due.pop_front());
            credit_return = 1'b1;
            outstanding--;
        end else begin
            credit_return = 1'b0;
        end
    endtask

    // sink model samples once per cycle at the falling edge
    always @(negedge clock) begin
        cycle_count++;
        if (pixel_valid)
            take_pixel();
        if (tri_done)
            finish_triangle();
        drive_credit_return();
    end

    initial begin
        int i;
        int wait_cycles;
        clock         = 1'b0;
        reset         = 1'b0;
        tri_valid     = 1'b0;
        x1            = '0;
        y1            = '0;
        x2            = '0;
        y2            = '0;
        x3            = '0;
        y3            = '0;
        color1        = '0;
        color2        = '0;
        color3        = '0;
        fb_base       = '0;
        credit_return = 1'b0;
        void'($urandom(32'h4610caa4));
        for (i = 0; i < 256; i++)
            delay_table[i] = $urandom % 7; // 0 to 6 cycles
        load_stimulus();
        if (tri_count == 0)
            stop_with_failure("the stimulus file holds no triangles");
        repeat (5) @(negedge clock);
        reset = 1'b1;

        // tri_valid stays high from one triangle to the next
        for (i = 0; i < tri_count; i++) begin
            apply_triangle(i);
            wait_cycles = 0;
            while (!tri_ready) begin
                @(negedge clock);
                wait_cycles++;
                if (wait_cycles > TIMEOUT)
                    stop_with_failure($sformatf("timed out waiting to hand over triangle %0d", i));
            end
            @(posedge clock);
            active.push_back(i);
            @(negedge clock);
            check_value(tri_ready, 0, "tri_ready after a triangle was taken");
        end
        tri_valid = 1'b0;

        wait_cycles = 0;
        while (done_count < tri_count || return_due.size() > 0) begin
            @(posedge clock);
            wait_cycles++;
            if (wait_cycles > TIMEOUT)
                stop_with_failure("timed out waiting for the last triangle and its credits");
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/raster_pkg.sv
logic/triangle_setup.sv
logic/scan_walker.sv
logic/edge_evaluator.sv
logic/credit_counter.sv
logic/raster_control.sv
logic/rasterizer_top.sv
verification/rasterizer_asserts.sv
verification/rasterizer_tb.sv

// ==== verification/raster_stimulus.txt ====
# x1 y1 x2 y2 x3 y3 (decimal) color1 color2 color3 fb_base (hex), then the expected
# pixel_count (decimal), first_addr and last_addr (hex); a zero count carries no addresses
0 0 0 4 4 0 ff0000 00ff00 0000ff 0100000 15 0100000 0105000
0 0 5 5 10 10 123456 654321 abcdef 0000000 0 0 0
10 20 10 30 20 20 00ff80 808080 101010 0000000 66 0019050 0025850
-20 -20 -20 -10 -10 -20 aaaaaa bbbbbb cccccc 0000000 0 0 0
-2 -2 -2 3 3 -2 0f0f0f f0f0f0 777777 0200000 3 0200000 0201400
0 0 4 0 0 4 111111 222222 333333 0000000 0 0 0
100 100 100 103 103 103 40c0e0 000001 000002 0000000 10 007d320 0080f38
700 10 700 20 710 10 fedcba 000000 ffffff 0000000 0 0 0
639 479 639 480 640 479 5a5a5a a5a5a5 3c3c3c 0000000 1 0257ff8 0257ff8
0 0 0 1 1 0 0000ff 00ff00 ff0000 3000000 3 3000000 3001400
